/* Makefile */
SRCS := $(wildcard src/*.sv src/*.svh sim/*.sv)

obj_dir/Vtb_rv_core: $(SRCS) all.f
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module tb_rv_core -o Vtb_rv_core

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core +verilator+error+limit+100 | tee sim.log
	@! grep -q "TEST RESULT: FAIL" sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* all.f */
+incdir+src
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

/* sim/rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva (
    input logic            clk,
    input logic            rst,
    input logic            inst_ack,
    input rv_pkg::retire_t retire,
    input logic            retire_req,
    input logic            retire_ack,
    input logic            halted
);

    int unsigned errors = 0;  // failure count, read from the testbench

    req_held: assert property (@(posedge clk) disable iff (rst)
        retire_req && !retire_ack |=> retire_req)
        else begin
            errors++;
            $error("retire_req dropped before retire_ack");
        end

    retire_stable: assert property (@(posedge clk) disable iff (rst)
        retire_req && !retire_ack |=> $stable(retire))
        else begin
            errors++;
            $error("retire record changed while retire_req was high");
        end

    reset_low: assert property (@(posedge clk)
        rst |=> !inst_ack && !retire_req)
        else begin
            errors++;
            $error("inst_ack or retire_req high during reset");
        end

    no_ack_halted: assert property (@(posedge clk) disable iff (rst)
        $past(halted) |-> !$rose(inst_ack))
        else begin
            errors++;
            $error("inst_ack rose after the core halted");
        end

endmodule

bind rv_core_top rv_core_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .inst_ack   (inst_ack),
    .retire     (retire),
    .retire_req (retire_req),
    .retire_ack (retire_ack),
    .halted     (halted)
);

/* sim/rv_tests.txt */
// first word: number of tests, then one test per line
// inst pc rd wdata next_pc flags (1 halt, 2 illegal, 4 wdata unchecked, 8 delayed ack)
00000022
12300093 00000100 01 00000123 00000104 0
FFB00113 00000104 02 FFFFFFFB 00000108 0
00112193 00000108 03 00000001 0000010C 0
00113213 0000010C 04 00000000 00000110 0
0F00C293 00000110 05 000001D3 00000114 8
7000E313 00000114 06 00000723 00000118 0
0FF17393 00000118 07 000000FB 0000011C 0
00409413 0000011C 08 00001230 00000120 0
00415493 00000120 09 0FFFFFFF 00000124 0
40415513 00000124 0A FFFFFFFF 00000128 0
123455B7 00000128 0B 12345000 0000012C 0
00001617 0000012C 0C 0000112C 00000130 0
002086B3 00000130 0D 0000011E 00000134 8
40208733 00000134 0E 00000128 00000138 0
001127B3 00000138 0F 00000001 0000013C 0
00113833 0000013C 10 00000000 00000140 0
007098B3 00000140 11 18000000 00000144 0
00315933 00000144 12 7FFFFFFD 00000148 0
403159B3 00000148 13 FFFFFFFD 0000014C 8
0060FA33 0000014C 14 00000123 00000150 0
0082EAB3 00000150 15 000013F3 00000154 0
00B0CB33 00000154 16 12345123 00000158 0
00508013 00000158 00 00000128 0000015C 0
00000BB3 0000015C 17 00000000 00000160 0
00108863 00000160 00 00000000 00000170 4
00109863 00000164 00 00000000 00000168 4
FE114CE3 00000168 00 00000000 00000160 C
FE115CE3 0000016C 00 00000000 00000170 4
00116863 00000170 00 00000000 00000174 4
00117863 00000174 00 00000000 00000184 4
10000C6F 00000178 18 0000017C 00000278 0
00208CE7 0000017C 19 00000180 00000124 0
0000AD03 00000180 00 00000000 00000184 6
00100073 00000184 00 00000000 00000188 5

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int MAX_TESTS      = 64;
    localparam int WORDS_PER_TEST = 6;

    logic            clk;
    logic            rst;
    logic            inst_req;
    rv_pkg::inst_t   inst;
    rv_pkg::word_t   inst_pc;
    logic            inst_ack;
    rv_pkg::retire_t retire;
    logic            retire_req;
    logic            retire_ack;
    logic            halted;

    logic [31:0] tests_mem [0:MAX_TESTS*WORDS_PER_TEST];  // word 0 is the test count
    int          num_tests;
    int          pass_count;
    int          fail_count;
    int          test_errs;
    integer      seed;
    logic        loaded;

    rv_core_top dut (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_ack   (inst_ack),
        .retire     (retire),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .halted     (halted)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string name, input rv_pkg::reg_addr_t got,
                             input rv_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic run_one(input int idx);
        rv_pkg::inst_t     t_inst;
        rv_pkg::word_t     t_pc;
        rv_pkg::reg_addr_t exp_rd;
        rv_pkg::word_t     exp_wdata;
        rv_pkg::word_t     exp_next;
        logic [3:0]        flags;
        rv_pkg::retire_t   seen;
        int                base;
        int                lat;
        int                delay;

        base      = 1 + idx * WORDS_PER_TEST;
        t_inst    = tests_mem[base];
        t_pc      = tests_mem[base + 1];
        exp_rd    = tests_mem[base + 2][4:0];
        exp_wdata = tests_mem[base + 3];
        exp_next  = tests_mem[base + 4];
        flags     = tests_mem[base + 5][3:0];  // halt, illegal, skip wdata, slow ack
        test_errs = 0;

        while (inst_ack) @(posedge clk);
        @(posedge clk);
        inst_req <= 1'b1;
        inst     <= t_inst;
        inst_pc  <= t_pc;
        do @(posedge clk); while (!inst_ack);
        inst_req <= 1'b0;

        lat = 1;  // ack seen one edge after capture
        while (!retire_req) begin
            @(posedge clk);
            lat++;
        end
        if (lat != 3) begin
            $display("retire_req rose %0d cycles after capture instead of 3", lat);
            test_errs++;
        end

        seen = retire;
        check_word("retire.pc", retire.pc, t_pc);
        check_reg("retire.rd", retire.rd, exp_rd);
        if (!flags[2])
            check_word("retire.wdata", retire.wdata, exp_wdata);
        check_word("retire.next_pc", retire.next_pc, exp_next);
        check_flag("retire.halt", retire.halt, flags[0]);
        check_flag("retire.illegal", retire.illegal, flags[1]);

        if (flags[3]) begin
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) @(posedge clk);
            check_flag("retire_req", retire_req, 1'b1);
            check_word("retire.pc", retire.pc, seen.pc);
            check_reg("retire.rd", retire.rd, seen.rd);
            check_word("retire.wdata", retire.wdata, seen.wdata);
            check_word("retire.next_pc", retire.next_pc, seen.next_pc);
        end

        retire_ack <= 1'b1;
        do @(posedge clk); while (retire_req);
        retire_ack <= 1'b0;
        check_flag("halted", halted, flags[0]);

        if (test_errs == 0)
            pass_count++;
        else
            fail_count++;
        $display("test %0d pc %h inst %h: %s", idx, t_pc, t_inst,
                 (test_errs == 0) ? "ok" : "mismatch");
    endtask

    // after ebreak a new request must never be acknowledged
    task automatic probe_halt();
        logic acked;

        acked = 1'b0;
        @(posedge clk);
        inst_req <= 1'b1;
        inst     <= 32'h00000013;  // addi x0, x0, 0
        inst_pc  <= 32'h00000188;
        repeat (20) begin
            @(posedge clk);
            if (inst_ack)
                acked = 1'b1;
        end
        inst_req <= 1'b0;
        if (acked) begin
            $display("halt probe: instruction was accepted after the core halted");
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("halt probe: %s", acked ? "mismatch" : "ok");
    endtask

    initial begin
        rst        = 1'b1;
        inst_req   = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        retire_ack = 1'b0;
        seed       = 24257;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        loaded     = 1'b0;

        $readmemh("sim/rv_tests.txt", tests_mem);
        num_tests = int'(tests_mem[0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            $display("test file gives no usable test count");
            fail_count++;
            num_tests = 0;
        end
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_tests; i++)
            run_one(i);
        if (num_tests > 0)
            probe_halt();

        if (dut.u_sva.errors != 0) begin
            $display("assertions failed %0d times", dut.u_sva.errors);
            fail_count++;
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // budget of 40 cycles per test, halt probe included, plus reset
    initial begin
        wait (loaded);
        repeat ((num_tests + 1) * 40 + 8) @(posedge clk);
        $display("watchdog expired, the run hung waiting on a handshake");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* src/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_req,
    input  rv_pkg::inst_t   inst,
    input  rv_pkg::word_t   inst_pc,
    output logic            inst_ack,
    output rv_pkg::retire_t retire,
    output logic            retire_req,
    input  logic            retire_ack,
    output logic            halted
);

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::decoded_t  dec;
    logic              dec_valid;
    rv_pkg::exec_t     ex;
    logic              exec_valid;
    logic              wr_en;
    rv_pkg::reg_addr_t wr_addr;
    rv_pkg::word_t     wr_data;
    logic              done;

    rv_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .inst_req  (inst_req),
        .inst      (inst),
        .inst_pc   (inst_pc),
        .inst_ack  (inst_ack),
        .done      (done),
        .halted    (halted),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .dec_valid  (dec_valid),
        .ex         (ex),
        .exec_valid (exec_valid)
    );

    rv_result u_result (
        .clk        (clk),
        .rst        (rst),
        .ex         (ex),
        .exec_valid (exec_valid),
        .retire     (retire),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .halted     (halted),
        .done       (done)
    );

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_req,
    input  rv_pkg::inst_t     inst,
    input  rv_pkg::word_t     inst_pc,
    output logic              inst_ack,
    input  logic              done,
    input  logic              halted,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::decoded_t  dec,
    output logic              dec_valid
);

    rv_pkg::dec_state_e state;
    rv_pkg::inst_t      inst_q;
    rv_pkg::word_t      pc_q;
    logic               accept;

    assign accept = (state == rv_pkg::dec_idle) && inst_req && !inst_ack && !halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rv_pkg::dec_idle;
            inst_ack <= 1'b0;
        end else begin
            case (state)
                rv_pkg::dec_idle:      if (accept) state <= rv_pkg::dec_hold;
                rv_pkg::dec_hold:      state <= rv_pkg::dec_wait_done;
                rv_pkg::dec_wait_done: if (done) state <= rv_pkg::dec_idle;
                default:               state <= rv_pkg::dec_idle;
            endcase
            if (accept)
                inst_ack <= 1'b1;
            else if (!inst_req)
                inst_ack <= 1'b0;  // four-phase release
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
            pc_q   <= inst_pc;
        end
    end

    assign dec_valid = (state == rv_pkg::dec_hold);

    wire [6:0] opcode = inst_q[6:0];
    wire [4:0] rd     = inst_q[11:7];
    wire [2:0] funct3 = inst_q[14:12];
    wire [4:0] rs1    = inst_q[19:15];
    wire [4:0] rs2    = inst_q[24:20];
    wire [6:0] funct7 = inst_q[31:25];
    wire [7:0] f3     = 8'b1 << funct3;

    wire opc_imm    = (opcode == `RV_OPC_IMM);
    wire opc_op     = (opcode == `RV_OPC_OP);
    wire opc_lui    = (opcode == `RV_OPC_LUI);
    wire opc_auipc  = (opcode == `RV_OPC_AUIPC);
    wire opc_jal    = (opcode == `RV_OPC_JAL);
    wire opc_jalr   = (opcode == `RV_OPC_JALR);
    wire opc_branch = (opcode == `RV_OPC_BRANCH);
    wire opc_system = (opcode == `RV_OPC_SYSTEM);

    wire f7_zero  = (funct7 == 7'b0000000);
    wire f7_alt   = (funct7 == 7'b0100000);  // sub and sra forms

    wire is_addi  = opc_imm & f3[0];
    wire is_slti  = opc_imm & f3[2];
    wire is_sltiu = opc_imm & f3[3];
    wire is_xori  = opc_imm & f3[4];
    wire is_ori   = opc_imm & f3[6];
    wire is_andi  = opc_imm & f3[7];
    wire is_slli  = opc_imm & f3[1] & f7_zero;
    wire is_srli  = opc_imm & f3[5] & f7_zero;
    wire is_srai  = opc_imm & f3[5] & f7_alt;
    wire is_add   = opc_op  & f3[0] & f7_zero;
    wire is_sub   = opc_op  & f3[0] & f7_alt;
    wire is_sll   = opc_op  & f3[1] & f7_zero;
    wire is_slt   = opc_op  & f3[2] & f7_zero;
    wire is_sltu  = opc_op  & f3[3] & f7_zero;
    wire is_xor   = opc_op  & f3[4] & f7_zero;
    wire is_srl   = opc_op  & f3[5] & f7_zero;
    wire is_sra   = opc_op  & f3[5] & f7_alt;
    wire is_or    = opc_op  & f3[6] & f7_zero;
    wire is_and   = opc_op  & f3[7] & f7_zero;
    wire is_jalr  = opc_jalr & f3[0];
    wire is_beq   = opc_branch & f3[0];
    wire is_bne   = opc_branch & f3[1];
    wire is_blt   = opc_branch & f3[4];
    wire is_bge   = opc_branch & f3[5];
    wire is_bltu  = opc_branch & f3[6];
    wire is_bgeu  = opc_branch & f3[7];
    wire is_ebreak = opc_system && (rd == 5'd0) && (funct3 == 3'd0) && (rs1 == 5'd0)
                     && (inst_q[31:20] == 12'd1);

    wire alu_legal = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
                     | is_slli | is_srli | is_srai | is_add | is_sub | is_sll | is_slt
                     | is_sltu | is_xor | is_srl | is_sra | is_or | is_and;
    wire br_legal  = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
    wire is_legal  = alu_legal | opc_lui | opc_auipc | opc_jal | is_jalr | br_legal
                     | is_ebreak;

    wire rv_pkg::word_t imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    wire rv_pkg::word_t imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    wire rv_pkg::word_t imm_u = {inst_q[31:12], 12'b0};
    wire rv_pkg::word_t imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    wire rv_pkg::word_t imm   = ({`RV_XLEN{opc_imm | opc_jalr}}  & imm_i) |
                                ({`RV_XLEN{opc_branch}}          & imm_b) |
                                ({`RV_XLEN{opc_lui | opc_auipc}} & imm_u) |
                                ({`RV_XLEN{opc_jal}}             & imm_j);

    wire src1_pc    = opc_auipc | opc_jal | opc_jalr;
    wire src2_imm   = opc_imm | opc_lui | opc_auipc;
    wire src2_plus4 = opc_jal | opc_jalr;
    wire no_wr      = opc_branch | is_ebreak | ~is_legal;

    assign rs1_addr = (opc_imm | opc_op | opc_branch | opc_jalr) ? rs1 : '0;
    assign rs2_addr = (opc_op | opc_branch) ? rs2 : '0;  // unused ports read x0

    always_comb begin
        dec.pc     = pc_q;
        dec.alu_a  = src1_pc ? pc_q : rs1_data;
        dec.alu_b  = src2_imm ? imm : (src2_plus4 ? rv_pkg::word_t'(4) : rs2_data);
        dec.br_rs1 = is_jalr ? rs1_data : '0;
        dec.br_a   = opc_branch ? rs1_data : '0;
        dec.br_b   = opc_branch ? rs2_data : '0;
        dec.imm    = imm;
        dec.rd     = no_wr ? '0 : rd;
        dec.halt   = is_ebreak;
        dec.illegal = ~is_legal;

        if (is_sub)                 dec.alu_op = rv_pkg::alu_sub;
        else if (is_slti | is_slt)  dec.alu_op = rv_pkg::alu_slt;
        else if (is_sltiu | is_sltu) dec.alu_op = rv_pkg::alu_sltu;
        else if (is_andi | is_and)  dec.alu_op = rv_pkg::alu_and;
        else if (is_ori | is_or)    dec.alu_op = rv_pkg::alu_or;
        else if (is_xori | is_xor)  dec.alu_op = rv_pkg::alu_xor;
        else if (is_slli | is_sll)  dec.alu_op = rv_pkg::alu_sll;
        else if (is_srli | is_srl)  dec.alu_op = rv_pkg::alu_srl;
        else if (is_srai | is_sra)  dec.alu_op = rv_pkg::alu_sra;
        else if (opc_lui)           dec.alu_op = rv_pkg::alu_pass_b;
        else                        dec.alu_op = rv_pkg::alu_add;  // addi, add, auipc, links

        if (opc_jal)      dec.branch_op = rv_pkg::br_jal;
        else if (is_jalr) dec.branch_op = rv_pkg::br_jalr;
        else if (is_beq)  dec.branch_op = rv_pkg::br_beq;
        else if (is_bne)  dec.branch_op = rv_pkg::br_bne;
        else if (is_blt)  dec.branch_op = rv_pkg::br_blt;
        else if (is_bge)  dec.branch_op = rv_pkg::br_bge;
        else if (is_bltu) dec.branch_op = rv_pkg::br_bltu;
        else if (is_bgeu) dec.branch_op = rv_pkg::br_bgeu;
        else              dec.branch_op = rv_pkg::br_none;
    end

endmodule

/* src/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath widths
`define RV_XLEN       32
`define RV_REG_AW     5

// major opcodes, inst[6:0]
`define RV_OPC_IMM    7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_SYSTEM 7'b1110011

`endif

/* src/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::decoded_t dec,
    input  logic             dec_valid,
    output rv_pkg::exec_t    ex,
    output logic             exec_valid
);

    rv_pkg::word_t alu_res;
    rv_pkg::word_t jalr_sum;
    rv_pkg::word_t next_pc;
    logic [4:0]    shamt;
    logic          lt_s;
    logic          lt_u;
    logic          br_eq;
    logic          br_lt;
    logic          br_ltu;
    logic          taken;

    assign shamt  = dec.alu_b[4:0];
    assign lt_s   = $signed(dec.alu_a) < $signed(dec.alu_b);
    assign lt_u   = dec.alu_a < dec.alu_b;
    assign br_eq  = (dec.br_a == dec.br_b);
    assign br_lt  = $signed(dec.br_a) < $signed(dec.br_b);
    assign br_ltu = dec.br_a < dec.br_b;

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_add:  alu_res = dec.alu_a + dec.alu_b;
            rv_pkg::alu_sub:  alu_res = dec.alu_a - dec.alu_b;
            rv_pkg::alu_slt:  alu_res = rv_pkg::word_t'(lt_s);
            rv_pkg::alu_sltu: alu_res = rv_pkg::word_t'(lt_u);
            rv_pkg::alu_and:  alu_res = dec.alu_a & dec.alu_b;
            rv_pkg::alu_or:   alu_res = dec.alu_a | dec.alu_b;
            rv_pkg::alu_xor:  alu_res = dec.alu_a ^ dec.alu_b;
            rv_pkg::alu_sll:  alu_res = dec.alu_a << shamt;
            rv_pkg::alu_srl:  alu_res = dec.alu_a >> shamt;
            rv_pkg::alu_sra:  alu_res = $signed(dec.alu_a) >>> shamt;
            default:          alu_res = dec.alu_b;  // pass_b for lui
        endcase
    end

    always_comb begin
        case (dec.branch_op)
            rv_pkg::br_jal:  taken = 1'b1;
            rv_pkg::br_beq:  taken = br_eq;
            rv_pkg::br_bne:  taken = !br_eq;
            rv_pkg::br_blt:  taken = br_lt;
            rv_pkg::br_bge:  taken = !br_lt;
            rv_pkg::br_bltu: taken = br_ltu;
            rv_pkg::br_bgeu: taken = !br_ltu;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum = dec.br_rs1 + dec.imm;

    always_comb begin
        if (dec.branch_op == rv_pkg::br_jalr)
            next_pc = jalr_sum & ~rv_pkg::word_t'(1);  // target bit 0 dropped
        else if (taken)
            next_pc = dec.pc + dec.imm;
        else
            next_pc = dec.pc + rv_pkg::word_t'(4);
    end

    always_ff @(posedge clk) begin
        if (rst)
            exec_valid <= 1'b0;
        else
            exec_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex.pc      <= dec.pc;
            ex.rd      <= dec.rd;
            ex.wdata   <= alu_res;
            ex.next_pc <= next_pc;
            ex.halt    <= dec.halt;
            ex.illegal <= dec.illegal;
        end
    end

endmodule

/* src/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
        alu_xor, alu_sll, alu_srl, alu_sra, alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_jal, br_jalr, br_beq, br_bne,
        br_blt, br_bge, br_bltu, br_bgeu
    } branch_op_e;

    typedef enum logic [1:0] {dec_idle, dec_hold, dec_wait_done} dec_state_e;
    typedef enum logic [1:0] {res_idle, res_req, res_wait_low} res_state_e;

    typedef struct packed {
        word_t      pc;
        alu_op_e    alu_op;
        word_t      alu_a;
        word_t      alu_b;
        branch_op_e branch_op;
        word_t      br_rs1;    // jalr base
        word_t      br_a;
        word_t      br_b;
        word_t      imm;
        reg_addr_t  rd;        // 0 when nothing is written
        logic       halt;
        logic       illegal;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     wdata;
        word_t     next_pc;
        logic      halt;
        logic      illegal;
    } exec_t;

    typedef exec_t retire_t;   // same record, seen at the retire port

endpackage

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data
);

    localparam int NUM_REGS = 1 << `RV_REG_AW;

    rv_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // x0 never written
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* src/rv_result.sv */
`timescale 1ns/1ps

module rv_result (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::exec_t     ex,
    input  logic              exec_valid,
    output rv_pkg::retire_t   retire,
    output logic              retire_req,
    input  logic              retire_ack,
    output logic              wr_en,
    output rv_pkg::reg_addr_t wr_addr,
    output rv_pkg::word_t     wr_data,
    output logic              halted,
    output logic              done
);

    rv_pkg::res_state_e state;
    rv_pkg::retire_t    rec;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= rv_pkg::res_idle;
            halted <= 1'b0;
        end else begin
            case (state)
                rv_pkg::res_idle: begin
                    if (exec_valid)
                        state <= rv_pkg::res_req;
                end
                rv_pkg::res_req: begin
                    if (retire_ack) begin
                        state <= rv_pkg::res_wait_low;
                        if (rec.halt)
                            halted <= 1'b1;  // sticky until reset
                    end
                end
                rv_pkg::res_wait_low: begin
                    if (!retire_ack)
                        state <= rv_pkg::res_idle;
                end
                default: state <= rv_pkg::res_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == rv_pkg::res_idle) && exec_valid)
            rec <= rv_pkg::retire_t'(ex);
    end

    assign retire     = rec;
    assign retire_req = (state == rv_pkg::res_req);

    // write lands on the edge where ack is first seen
    assign wr_en   = retire_req && retire_ack && (rec.rd != '0);
    assign wr_addr = rec.rd;
    assign wr_data = rec.wdata;

    assign done = (state == rv_pkg::res_wait_low) && !retire_ack;  // one cycle

endmodule
